//--- vlog.f
+incdir+hw
+incdir+verif
hw/tpm_fifo_pkg.sv
hw/tpm_locality_arb.sv
hw/tpm_sts_fsm.sv
hw/tpm_int_ctrl.sv
hw/tpm_data_buffer.sv
hw/tpm_reg_decode.sv
hw/tpm_fifo_top.sv
verif/tpm_fifo_tb.sv

//--- Makefile
# Verilator flow for the TPM FIFO register space

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tpm_fifo_tb
RTL_TOP   ?= tpm_fifo_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tpm_fifo_model.svh
// Reference model of the TPM FIFO register space
// Localities, command status flow, interrupts and static register bytes
`ifndef TPM_FIFO_MODEL_SVH
`define TPM_FIFO_MODEL_SVH

// Status lifecycle codes, model side
localparam int M_IDLE = 0;
localparam int M_READY = 1;
localparam int M_RECEPTION = 2;
localparam int M_EXECUTION = 3;
localparam int M_COMPLETION = 4;

int m_active = -1;		// -1 while nobody holds the TPM
logic [4:0] m_pending = '0;
logic [4:0] m_seized = '0;
int m_state = M_IDLE;
int m_cmd_cnt = 0;
int m_cmd_len = 0;
int m_rsp_left = 0;
logic m_glob = 1'b0;
logic m_cr_en = 1'b0;
logic m_lc_en = 1'b0;
logic m_da_en = 1'b0;
logic [7:0] m_int_sts = '0;

// Highest pending locality takes the TPM
function automatic void model_grant_top();
	for (int i = 4; i >= 0; i--)
	begin
		if (m_pending[i] && m_active < 0)
		begin
			m_active = i;
			m_pending[i] = 1'b0;
		end
	end
endfunction

function automatic void model_request(int loc);
	if (loc != m_active)
		m_pending[loc] = 1'b1;
	if (m_active < 0)
		model_grant_top();
endfunction

function automatic void model_relinquish(int loc);
	m_pending[loc] = 1'b0;
	if (loc == m_active)
	begin
		m_active = -1;
		model_grant_top();
	end
endfunction

// Seize also requests use
function automatic void model_seize(int loc);
	if (loc != m_active)
		m_pending[loc] = 1'b1;
	if (m_active >= 0 && loc > m_active)
	begin
		m_seized[m_active] = 1'b1;
		m_active = -1;
		model_grant_top();
	end
endfunction

function automatic logic [7:0] exp_access(int loc);
	logic [4:0] others;
	others = m_pending & ~(5'b1 << loc);
	return {1'b1, 1'b0, (loc == m_active), m_seized[loc], 1'b0, |others, m_pending[loc], 1'b1};
endfunction

// State change, with the interrupt causes it raises
function automatic void model_enter(int st);
	if (st == M_READY && m_glob && m_cr_en)
		m_int_sts[7] = 1'b1;
	if (st == M_COMPLETION && m_rsp_left > 0 && m_glob && m_da_en)
		m_int_sts[0] = 1'b1;
	if (st == M_IDLE)
	begin
		m_cmd_cnt = 0;
		m_rsp_left = 0;
	end
	m_state = st;
endfunction

function automatic logic [7:0] exp_sts0();
	logic cr, ex, av;
	cr = (m_state == M_READY);
	ex = (m_state == M_RECEPTION) && (m_cmd_cnt < m_cmd_len);
	av = (m_state == M_COMPLETION) && (m_rsp_left > 0);
	return {1'b1, cr, 1'b0, av, ex, 3'b000};	// stsValid always set
endfunction

function automatic logic [7:0] exp_int_en(int b);
	if (b == 0)
		return {m_cr_en, 2'b00, 2'b01, m_lc_en, 1'b0, m_da_en};
	else if (b == 3)
		return {m_glob, 7'd0};
	return 8'h00;
endfunction

function automatic logic exp_pirq_n();
	return ~|m_int_sts;
endfunction

// Read-only registers from the header constants
function automatic logic [7:0] exp_static(logic [11:0] ofs);
	logic [31:0] w;
	case ({ofs[11:2], 2'b00})
	`TPM_CAP_OFS:    w = `TPM_CAP_BYTES;
	`TPM_IFID_OFS:   w = `TPM_IFID_BYTES;
	`TPM_DIDVID_OFS: w = {`TPM_DID, `TPM_VID};
	`TPM_RID_OFS:    w = {24'hFF_FFFF, `TPM_RID};
	`TPM_STS_OFS:    w = {`TPM_STS_B3, `TPM_BURST_COUNT, 8'h00};
	default:         w = {4{`TPM_READ_IDLE}};
	endcase
	return w[8*ofs[1:0] +: 8];
endfunction

`endif

//--- verif/tpm_fifo_tb.sv
// Testbench for the TPM FIFO register space
// Random localities and commands checked against the reference model
`timescale 1ns/1ps
`include "tpm_fifo_consts.svh"

module tpm_fifo_tb;

	localparam int NUM_TESTS = 6;	// Full commands run
	localparam int MAX_LEN = `TPM_BUF_DEPTH;
	localparam int TEST_CYCLES = MAX_LEN * 16 + 200;
	localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 4) * TEST_CYCLES * 8;
	localparam logic [11:0] STATIC_OFS [17] = '{12'h014, 12'h015, 12'h016, 12'h017,
		12'h019, 12'h01A, 12'h01B, 12'h030, 12'h031, 12'h032, 12'h033,
		12'hF00, 12'hF01, 12'hF02, 12'hF03, 12'hF04, 12'h040};

	logic clock = 1'b0;
	logic reset_n;
	logic req_i, we_i, rsp_we_i, exec_done_i;
	logic [15:0] addr_i;
	logic [7:0] wdata_i, rdata_o, cmd_byte_o, rsp_byte_i;
	logic [5:0] cmd_rd_addr_i;
	logic exec_start_o, pirq_n_o;
	logic [4:0] locality_o;
	logic [31:0] lfsr = 32'hf4fd845b;
	int errors = 0;
	int loc_a, loc_b, loc_c, loc_x;

	`include "tpm_fifo_model.svh"

	tpm_fifo_top i_tpm_fifo_top
	(
		.clock(clock), .reset_n(reset_n),
		.req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .rdata_o(rdata_o),
		.cmd_rd_addr_i(cmd_rd_addr_i), .cmd_byte_o(cmd_byte_o),
		.rsp_we_i(rsp_we_i), .rsp_byte_i(rsp_byte_i),
		.exec_start_o(exec_start_o), .exec_done_i(exec_done_i),
		.pirq_n_o(pirq_n_o), .locality_o(locality_o)
	);

	always #4 clock = ~clock;	// 8 ns period

	// Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	// One byte access driven 1 ns after the edge
	task automatic reg_write(input int loc, input logic [11:0] ofs, input logic [7:0] d);
		req_i = 1'b1;
		we_i = 1'b1;
		addr_i = {4'(loc), ofs};
		wdata_i = d;
		@(posedge clock);
		#1;
		req_i = 1'b0;
		we_i = 1'b0;
	endtask

	task automatic reg_read(input int loc, input logic [11:0] ofs, output logic [7:0] d);
		req_i = 1'b1;
		we_i = 1'b0;
		addr_i = {4'(loc), ofs};
		@(posedge clock);
		#1;
		req_i = 1'b0;
		d = rdata_o;	// Registered at that edge
	endtask

	task automatic read_check(input string name, input int loc, input logic [11:0] ofs,
		input logic [7:0] exp);
		logic [7:0] v;
		reg_read(loc, ofs, v);
		check(name, v, exp);
	endtask

	task automatic wait_grant(input int loc);
		logic [7:0] v;
		for (int i = 0; i < 10; i++)
		begin
			reg_read(loc, `TPM_ACCESS_OFS, v);
			if (v[5])
				return;
		end
		stop_run($sformatf("locality %0d was never granted", loc));
	endtask

	// Random byte address in one of the two data windows
	function automatic logic [11:0] fifo_ofs();
		logic [11:0] base;
		base = rand_bits(1) ? `TPM_XFIFO_LO : `TPM_FIFO_LO;
		return base + 12'(rand_bits(2));
	endfunction

	task automatic run_command(input int loc, input logic with_int);
		logic [7:0] cmd [MAX_LEN];
		logic [7:0] rsp [MAX_LEN];
		logic [7:0] v;
		int len, rlen, n;
		len = 6 + int'(rand_bits(6) % 59);	// 6 to 64 bytes
		rlen = 1 + int'(rand_bits(6));
		for (int i = 0; i < MAX_LEN; i++)
		begin
			cmd[i] = 8'(rand_bits(8));
			rsp[i] = 8'(rand_bits(8));
		end
		{cmd[2], cmd[3], cmd[4], cmd[5]} = 32'(len);	// Big-endian size
		m_cmd_len = len;
		reg_write(loc, `TPM_STS_OFS, 8'h40);
		model_enter(M_READY);
		if (with_int)
		begin
			idle(1);	// Status bit lands a cycle later
			read_check("TPM_INT_STATUS", loc, `TPM_INT_STS_OFS, m_int_sts);
			check("pirq_n_o", pirq_n_o, exp_pirq_n());
			reg_write(loc, `TPM_INT_STS_OFS, 8'h80);
			m_int_sts[7] = 1'b0;
			check("pirq_n_o", pirq_n_o, exp_pirq_n());
		end
		read_check("TPM_STS", loc, `TPM_STS_OFS, exp_sts0());
		for (int i = 0; i < len; i++)
		begin
			reg_write(loc, fifo_ofs(), cmd[i]);
			m_cmd_cnt++;
			m_state = M_RECEPTION;
			read_check("TPM_STS expect", loc, `TPM_STS_OFS, exp_sts0());
		end
		reg_write(loc, `TPM_STS_OFS, 8'h20);	// tpmGo
		n = 0;
		while (!exec_start_o)
		begin
			idle(1);
			n++;
			if (n > 20)
				stop_run("exec_start_o never pulsed after go");
		end
		model_enter(M_EXECUTION);
		idle(1);
		check("exec_start_o", exec_start_o, 1'b0);
		for (int i = 0; i < len; i++)
		begin
			cmd_rd_addr_i = 6'(i);
			idle(1);
			check($sformatf("cmd_byte_o[%0d]", i), cmd_byte_o, cmd[i]);
		end
		idle(1 + int'(rand_bits(4)));	// Engine latency
		for (int j = 0; j < rlen; j++)
		begin
			rsp_we_i = 1'b1;
			rsp_byte_i = rsp[j];
			idle(1);
		end
		rsp_we_i = 1'b0;
		exec_done_i = 1'b1;
		idle(1);
		exec_done_i = 1'b0;
		m_rsp_left = rlen;
		model_enter(M_COMPLETION);
		for (int j = 0; j < rlen; j++)
		begin
			read_check("TPM_STS dataAvail", loc, `TPM_STS_OFS, exp_sts0());
			read_check($sformatf("rsp byte %0d", j), loc, fifo_ofs(), rsp[j]);
			m_rsp_left--;
		end
		read_check("TPM_STS drained", loc, `TPM_STS_OFS, exp_sts0());
		if (with_int)
		begin
			read_check("TPM_INT_STATUS", loc, `TPM_INT_STS_OFS, m_int_sts);
			check("pirq_n_o", pirq_n_o, exp_pirq_n());
			reg_write(loc, `TPM_INT_STS_OFS, 8'h01);
			m_int_sts[0] = 1'b0;
			check("pirq_n_o", pirq_n_o, exp_pirq_n());
		end
		reg_write(loc, `TPM_STS_OFS, 8'h40);	// Back to Idle
		model_enter(M_IDLE);
		read_check("TPM_STS idle", loc, `TPM_STS_OFS, exp_sts0());
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before the tests finished");
	end

	initial
	begin
		int k;
		logic [7:0] d;
		reset_n = 1'b0;
		req_i = 1'b0;
		we_i = 1'b0;
		addr_i = '0;
		wdata_i = '0;
		cmd_rd_addr_i = '0;
		rsp_we_i = 1'b0;
		rsp_byte_i = '0;
		exec_done_i = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		reset_n = 1'b1;
		check("locality_o", locality_o, 5'd0);
		check("exec_start_o", exec_start_o, 1'b0);
		check("pirq_n_o", pirq_n_o, 1'b1);
		check("rdata_o", rdata_o, 8'hFF);

		// Request, pending, relinquish and seize
		loc_a = 1 + int'(rand_bits(2) % 3);
		loc_b = int'(rand_bits(3) % loc_a);
		loc_c = loc_b + 1 + int'(rand_bits(3) % (4 - loc_b));
		reg_write(loc_a, `TPM_ACCESS_OFS, 8'h02);
		model_request(loc_a);
		wait_grant(loc_a);
		check("locality_o", locality_o, 5'b1 << loc_a);
		reg_write(loc_b, `TPM_ACCESS_OFS, 8'h02);
		model_request(loc_b);
		read_check("TPM_ACCESS pending", loc_b, `TPM_ACCESS_OFS, exp_access(loc_b));
		read_check("TPM_ACCESS owner", loc_a, `TPM_ACCESS_OFS, exp_access(loc_a));
		reg_write(loc_a, `TPM_ACCESS_OFS, 8'h20);
		model_relinquish(loc_a);
		wait_grant(loc_b);
		check("locality_o", locality_o, 5'b1 << loc_b);
		read_check("TPM_ACCESS released", loc_a, `TPM_ACCESS_OFS, exp_access(loc_a));
		reg_write(loc_c, `TPM_ACCESS_OFS, 8'h08);
		model_seize(loc_c);
		wait_grant(loc_c);
		check("locality_o", locality_o, 5'b1 << loc_c);
		read_check("TPM_ACCESS seized", loc_b, `TPM_ACCESS_OFS, exp_access(loc_b));
		reg_write(loc_b, `TPM_ACCESS_OFS, 8'h10);
		m_seized[loc_b] = 1'b0;
		read_check("TPM_ACCESS cleared", loc_b, `TPM_ACCESS_OFS, exp_access(loc_b));

		// Read-only registers
		foreach (STATIC_OFS[i])
			read_check($sformatf("reg 0x%0h", STATIC_OFS[i]), loc_c, STATIC_OFS[i],
				exp_static(STATIC_OFS[i]));

		// Inactive locality is shut out
		loc_x = (loc_c + 1 + int'(rand_bits(2))) % 5;
		read_check("TPM_STS inactive", loc_x, `TPM_STS_OFS, 8'hFF);
		reg_write(loc_x, `TPM_INT_EN_OFS, 8'h85);
		read_check("TPM_INT_ENABLE", loc_c, `TPM_INT_EN_OFS, exp_int_en(0));

		// First command with commandReady and dataAvail interrupts
		reg_write(loc_c, `TPM_INT_EN_OFS + 12'd3, 8'h80);
		reg_write(loc_c, `TPM_INT_EN_OFS, 8'h81);
		{m_glob, m_cr_en, m_da_en} = 3'b111;
		read_check("TPM_INT_ENABLE b0", loc_c, `TPM_INT_EN_OFS, exp_int_en(0));
		read_check("TPM_INT_ENABLE b3", loc_c, `TPM_INT_EN_OFS + 12'd3, exp_int_en(3));
		run_command(loc_c, 1'b1);
		reg_write(loc_c, `TPM_INT_EN_OFS + 12'd3, 8'h00);
		m_glob = 1'b0;

		// Abort during reception
		m_cmd_len = MAX_LEN;
		reg_write(loc_c, `TPM_STS_OFS, 8'h40);
		model_enter(M_READY);
		k = 1 + int'(rand_bits(5));
		for (int i = 0; i < k; i++)
		begin
			d = 8'(rand_bits(8));
			if (i >= 2 && i <= 5)
				d = 8'(MAX_LEN >> (8 * (5 - i)));	// Size field asks for a full buffer
			reg_write(loc_c, fifo_ofs(), d);
			m_cmd_cnt++;
			m_state = M_RECEPTION;
		end
		read_check("TPM_STS partial", loc_c, `TPM_STS_OFS, exp_sts0());
		reg_write(loc_c, `TPM_STS_OFS, 8'h40);
		model_enter(M_IDLE);
		read_check("TPM_STS aborted", loc_c, `TPM_STS_OFS, exp_sts0());

		for (int t = 1; t < NUM_TESTS; t++)
			run_command(loc_c, 1'b0);

		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- hw/tpm_fifo_top.sv
// TPM 2.0 FIFO register space top level
// Connects decoder, locality arbiter, status FSM, interrupts and buffers
`timescale 1ns/1ps
`include "tpm_fifo_consts.svh"

module tpm_fifo_top
(
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     req_i,		// One byte per pulse
	input  logic                     we_i,
	input  logic [`TPM_ADDR_W-1:0]   addr_i,	// Locality in 15:12
	input  logic [7:0]               wdata_i,
	output logic [7:0]               rdata_o,
	input  logic [`TPM_BUF_AW-1:0]   cmd_rd_addr_i,
	output logic [7:0]               cmd_byte_o,
	input  logic                     rsp_we_i,
	input  logic [7:0]               rsp_byte_i,
	output logic                     exec_start_o,
	input  logic                     exec_done_i,
	output logic                     pirq_n_o,
	output logic [`TPM_NUM_LOC-1:0]  locality_o
);

	// Decoder strobes
	logic [`TPM_NUM_LOC-1:0] loc_grant_req, loc_seize, loc_release;
	logic cmd_ready_wr, go_wr, fifo_wr, fifo_rd;
	logic int_en_wr, int_glob_wr, int_stat_clr;
	logic [7:0] fifo_wdata, fifo_rdata;

	// Arbiter state
	logic [2:0] active_loc, seized_loc;
	logic loc_valid, seized, loc_change;
	logic [`TPM_NUM_LOC-1:0] pending;

	// Status and interrupt state
	tpm_fifo_pkg::sts_state_t sts_state;
	logic cmd_ready, expect_flag, data_avail, buf_clear;
	logic cmd_complete, rsp_empty;
	logic [31:0] int_enable;
	logic [7:0] int_status;
	wire exec_busy = (sts_state == tpm_fifo_pkg::EXECUTION);

	tpm_reg_decode i_tpm_reg_decode
	(
		.clock(clock), .reset_n(reset_n),
		.req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i), .rdata_o(rdata_o),
		.active_loc_i(active_loc), .loc_valid_i(loc_valid), .pending_i(pending),
		.seized_i(seized), .seized_loc_i(seized_loc),
		.sts_state_i(sts_state), .cmd_ready_i(cmd_ready), .expect_i(expect_flag),
		.data_avail_i(data_avail), .int_enable_i(int_enable), .int_status_i(int_status),
		.fifo_rdata_i(fifo_rdata),
		.loc_grant_req_o(loc_grant_req), .loc_seize_o(loc_seize), .loc_release_o(loc_release),
		.cmd_ready_wr_o(cmd_ready_wr), .go_wr_o(go_wr),
		.fifo_wr_o(fifo_wr), .fifo_rd_o(fifo_rd), .fifo_wdata_o(fifo_wdata),
		.int_en_wr_o(int_en_wr), .int_glob_wr_o(int_glob_wr), .int_stat_clr_o(int_stat_clr)
	);

	tpm_locality_arb i_tpm_locality_arb
	(
		.clock(clock), .reset_n(reset_n),
		.loc_grant_req_i(loc_grant_req), .loc_seize_i(loc_seize), .loc_release_i(loc_release),
		.active_loc_o(active_loc), .loc_valid_o(loc_valid), .locality_o(locality_o),
		.seized_o(seized), .seized_loc_o(seized_loc), .loc_change_o(loc_change),
		.pending_o(pending)
	);

	tpm_sts_fsm i_tpm_sts_fsm
	(
		.clock(clock), .reset_n(reset_n),
		.cmd_ready_wr_i(cmd_ready_wr), .go_wr_i(go_wr), .fifo_wr_i(fifo_wr), .seized_i(seized),
		.cmd_complete_i(cmd_complete), .rsp_empty_i(rsp_empty), .exec_done_i(exec_done_i),
		.exec_start_o(exec_start_o), .sts_state_o(sts_state), .cmd_ready_o(cmd_ready),
		.expect_o(expect_flag), .data_avail_o(data_avail), .buf_clear_o(buf_clear)
	);

	tpm_int_ctrl i_tpm_int_ctrl
	(
		.clock(clock), .reset_n(reset_n),
		.en_wr_i(int_en_wr), .glob_wr_i(int_glob_wr), .stat_clr_i(int_stat_clr),
		.wdata_i(wdata_i), .cmd_ready_i(cmd_ready), .data_avail_i(data_avail),
		.loc_change_i(loc_change), .int_enable_o(int_enable), .int_status_o(int_status),
		.pirq_n_o(pirq_n_o)
	);

	tpm_data_buffer i_tpm_data_buffer
	(
		.clock(clock), .reset_n(reset_n),
		.clear_i(buf_clear), .fifo_wr_i(fifo_wr), .fifo_rd_i(fifo_rd), .wdata_i(fifo_wdata),
		.expect_i(expect_flag), .exec_i(exec_busy), .rdata_o(fifo_rdata),
		.cmd_complete_o(cmd_complete), .rsp_empty_o(rsp_empty),
		.cmd_rd_addr_i(cmd_rd_addr_i), .cmd_byte_o(cmd_byte_o),
		.rsp_we_i(rsp_we_i), .rsp_byte_i(rsp_byte_i)
	);

endmodule

//--- hw/tpm_reg_decode.sv
// FIFO register space decoder
// Locality check, TPM_ACCESS bits, read mux and write strobes
`timescale 1ns/1ps
`include "tpm_fifo_consts.svh"

module tpm_reg_decode
(
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     req_i,
	input  logic                     we_i,
	input  logic [`TPM_ADDR_W-1:0]   addr_i,
	input  logic [7:0]               wdata_i,
	output logic [7:0]               rdata_o,		// Valid the cycle after req_i
	input  logic [2:0]               active_loc_i,
	input  logic                     loc_valid_i,
	input  logic [`TPM_NUM_LOC-1:0]  pending_i,
	input  logic                     seized_i,
	input  logic [2:0]               seized_loc_i,
	input  tpm_fifo_pkg::sts_state_t sts_state_i,
	input  logic                     cmd_ready_i,
	input  logic                     expect_i,
	input  logic                     data_avail_i,
	input  logic [31:0]              int_enable_i,
	input  logic [7:0]               int_status_i,
	input  logic [7:0]               fifo_rdata_i,
	output logic [`TPM_NUM_LOC-1:0]  loc_grant_req_o,
	output logic [`TPM_NUM_LOC-1:0]  loc_seize_o,
	output logic [`TPM_NUM_LOC-1:0]  loc_release_o,
	output logic                     cmd_ready_wr_o,
	output logic                     go_wr_o,
	output logic                     fifo_wr_o,
	output logic                     fifo_rd_o,
	output logic [7:0]               fifo_wdata_o,
	output logic                     int_en_wr_o,
	output logic                     int_glob_wr_o,
	output logic                     int_stat_clr_o
);

	logic [11:0] ofs, ofs_word;
	logic [`TPM_NUM_LOC-1:0] loc_sel, been_seized, seize_set;
	logic loc_ok, allow, acc_hit, acc_wr, reg_wr, sts_wr, fifo_hit, rx_ok;
	logic [7:0] access_byte, sts_byte, rd_byte;
	logic [31:0] rd_word;

	assign ofs      = addr_i[11:0];
	assign ofs_word = {ofs[11:2], 2'b00};
	assign loc_ok   = addr_i[15:12] < `TPM_NUM_LOC;
	assign loc_sel  = {{(`TPM_NUM_LOC-1){1'b0}}, 1'b1} << addr_i[14:12];	// Zero past locality 4
	assign allow    = loc_ok && loc_valid_i && ({1'b0, active_loc_i} == addr_i[15:12]);
	assign acc_hit  = loc_ok && (ofs == `TPM_ACCESS_OFS);	// Open to every locality
	assign fifo_hit = (ofs >= `TPM_FIFO_LO && ofs <= `TPM_FIFO_HI) ||
	                  (ofs >= `TPM_XFIFO_LO && ofs <= `TPM_XFIFO_HI);

	// Write strobes
	assign acc_wr = req_i && we_i && acc_hit;
	assign reg_wr = req_i && we_i && allow;
	assign sts_wr = reg_wr && (ofs == `TPM_STS_OFS);
	assign rx_ok  = (sts_state_i == tpm_fifo_pkg::READY) ||
	                (sts_state_i == tpm_fifo_pkg::RECEPTION);

	assign loc_grant_req_o = (acc_wr && (wdata_i[1] || wdata_i[3])) ? loc_sel : '0;
	assign loc_seize_o     = (acc_wr && wdata_i[3]) ? loc_sel : '0;
	assign loc_release_o   = (acc_wr && wdata_i[5]) ? loc_sel : '0;
	assign cmd_ready_wr_o  = sts_wr && wdata_i[6];
	assign go_wr_o         = sts_wr && wdata_i[5];
	assign int_en_wr_o     = reg_wr && (ofs == `TPM_INT_EN_OFS);
	assign int_glob_wr_o   = reg_wr && (ofs == `TPM_INT_EN_OFS + 12'd3);
	assign int_stat_clr_o  = reg_wr && (ofs == `TPM_INT_STS_OFS);
	assign fifo_wr_o       = reg_wr && fifo_hit && rx_ok;	// Writes outside Ready/Reception dropped
	assign fifo_rd_o       = req_i && !we_i && allow && fifo_hit && data_avail_i;
	assign fifo_wdata_o    = wdata_i;

	// beenSeized per locality, set by the arbiter, cleared by writing bit 4
	assign seize_set = seized_i ? ({{(`TPM_NUM_LOC-1){1'b0}}, 1'b1} << seized_loc_i) : '0;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			been_seized <= '0;
		else
			been_seized <= seize_set | (been_seized & ~((acc_wr && wdata_i[4]) ? loc_sel : '0));
	end

	// TPM_ACCESS for the addressed locality
	assign access_byte =
	{
		1'b1,				// tpmRegValidSts
		1'b0,
		allow,				// activeLocality
		|(been_seized & loc_sel),
		1'b0,				// Seize reads 0
		|(pending_i & ~loc_sel),	// pendingRequest from others
		|(pending_i & loc_sel),		// requestUse
		1'b1				// tpmEstablishment
	};

	// stsValid always set, no internal delay
	assign sts_byte = {1'b1, cmd_ready_i, 1'b0, data_avail_i, expect_i, 3'b000};

	always_comb
	begin
		case (ofs_word)
		`TPM_ACCESS_OFS:  rd_word = {24'hFF_FFFF, access_byte};
		`TPM_INT_EN_OFS:  rd_word = int_enable_i;
		`TPM_INT_STS_OFS: rd_word = {24'd0, int_status_i};
		`TPM_CAP_OFS:     rd_word = `TPM_CAP_BYTES;
		`TPM_STS_OFS:     rd_word = {`TPM_STS_B3, `TPM_BURST_COUNT, sts_byte};
		`TPM_IFID_OFS:    rd_word = `TPM_IFID_BYTES;
		`TPM_DIDVID_OFS:  rd_word = {`TPM_DID, `TPM_VID};
		`TPM_RID_OFS:     rd_word = {24'hFF_FFFF, `TPM_RID};
		default:          rd_word = {4{`TPM_READ_IDLE}};
		endcase

		if (fifo_hit)
			rd_byte = data_avail_i ? fifo_rdata_i : `TPM_READ_IDLE;	// Empty window reads idle
		else
			rd_byte = rd_word[{ofs[1:0], 3'b000} +: 8];

		if (!allow && !acc_hit)
			rd_byte = `TPM_READ_IDLE;	// Other localities see nothing
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
			rdata_o <= `TPM_READ_IDLE;
		else
			rdata_o <= (req_i && !we_i) ? rd_byte : `TPM_READ_IDLE;
	end

endmodule

//--- hw/tpm_data_buffer.sv
// Command and response byte buffers
// Captures the header size field and tracks fill and drain counts
`timescale 1ns/1ps
`include "tpm_fifo_consts.svh"

module tpm_data_buffer
(
	input  logic                   clock,
	input  logic                   reset_n,
	input  logic                   clear_i,
	input  logic                   fifo_wr_i,
	input  logic                   fifo_rd_i,
	input  logic [7:0]             wdata_i,
	input  logic                   expect_i,
	input  logic                   exec_i,
	output logic [7:0]             rdata_o,		// Head of response, combinational
	output logic                   cmd_complete_o,
	output logic                   rsp_empty_o,
	input  logic [`TPM_BUF_AW-1:0] cmd_rd_addr_i,
	output logic [7:0]             cmd_byte_o,
	input  logic                   rsp_we_i,
	input  logic [7:0]             rsp_byte_i
);

	logic [7:0] cmd_mem [`TPM_BUF_DEPTH];
	logic [7:0] rsp_mem [`TPM_BUF_DEPTH];
	logic [`TPM_BUF_AW:0] cmd_cnt, rsp_wr_cnt, rsp_rd_cnt;	// MSB set means full
	logic [31:0] cmd_size;		// Big-endian header bytes 2-5
	logic cmd_take, rsp_take, rd_take;

	// First byte lands in Ready before Expect rises
	assign cmd_take = fifo_wr_i && (expect_i || cmd_cnt == '0) && !cmd_cnt[`TPM_BUF_AW];
	assign rsp_take = rsp_we_i && exec_i && !rsp_wr_cnt[`TPM_BUF_AW];
	assign rd_take  = fifo_rd_i && !rsp_empty_o;

	assign cmd_complete_o = (cmd_cnt >= 6) && (32'(cmd_cnt) >= cmd_size);
	assign rsp_empty_o    = (rsp_rd_cnt == rsp_wr_cnt);
	assign rdata_o        = rsp_mem[rsp_rd_cnt[`TPM_BUF_AW-1:0]];
	assign cmd_byte_o     = cmd_mem[cmd_rd_addr_i];

	always_ff @(posedge clock)
	begin
		if (cmd_take)
			cmd_mem[cmd_cnt[`TPM_BUF_AW-1:0]] <= wdata_i;
		if (rsp_take)
			rsp_mem[rsp_wr_cnt[`TPM_BUF_AW-1:0]] <= rsp_byte_i;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			cmd_cnt    <= '0;
			rsp_wr_cnt <= '0;
			rsp_rd_cnt <= '0;
			cmd_size   <= '0;
		end
		else if (clear_i)
		begin
			cmd_cnt    <= '0;
			rsp_wr_cnt <= '0;
			rsp_rd_cnt <= '0;
			cmd_size   <= '0;
		end
		else
		begin
			if (cmd_take)
			begin
				cmd_cnt <= cmd_cnt + 1'b1;
				if (cmd_cnt >= 2 && cmd_cnt <= 5)
					cmd_size <= {cmd_size[23:0], wdata_i};	// Shift in MSB first
			end
			if (rsp_take)
				rsp_wr_cnt <= rsp_wr_cnt + 1'b1;
			if (rd_take)
				rsp_rd_cnt <= rsp_rd_cnt + 1'b1;
		end
	end

	a_rsp_in_exec: assert property (@(posedge clock) disable iff (!reset_n)
		rsp_we_i |-> exec_i);

endmodule

//--- hw/tpm_int_ctrl.sv
// Interrupt block
// TPM_INT_ENABLE, sticky TPM_INT_STATUS and the active-low PIRQ
`timescale 1ns/1ps

module tpm_int_ctrl
(
	input  logic        clock,
	input  logic        reset_n,
	input  logic        en_wr_i,		// TPM_INT_ENABLE byte 0
	input  logic        glob_wr_i,		// TPM_INT_ENABLE byte 3
	input  logic        stat_clr_i,		// TPM_INT_STATUS byte 0
	input  logic [7:0]  wdata_i,
	input  logic        cmd_ready_i,
	input  logic        data_avail_i,
	input  logic        loc_change_i,
	output logic [31:0] int_enable_o,
	output logic [7:0]  int_status_o,
	output logic        pirq_n_o
);

	logic glob_en, cr_en, lc_en, da_en;
	logic cr_sts, lc_sts, da_sts;
	logic cr_q, da_q;	// Previous flag values for edge detect
	logic cr_set, lc_set, da_set;

	assign cr_set = glob_en && cr_en && cmd_ready_i && !cr_q;
	assign da_set = glob_en && da_en && data_avail_i && !da_q;
	assign lc_set = glob_en && lc_en && loc_change_i;	// Level, every handover cycle

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			{glob_en, cr_en, lc_en, da_en} <= 4'b0000;
			{cr_sts, lc_sts, da_sts} <= 3'b000;
			{cr_q, da_q} <= 2'b00;
		end
		else
		begin
			cr_q <= cmd_ready_i;
			da_q <= data_avail_i;
			if (glob_wr_i)
				glob_en <= wdata_i[7];
			if (en_wr_i)
			begin
				cr_en <= wdata_i[7];
				lc_en <= wdata_i[2];
				da_en <= wdata_i[0];
			end
			// Write 1 clears, a new cause wins
			cr_sts <= cr_set | (cr_sts & ~(stat_clr_i & wdata_i[7]));
			lc_sts <= lc_set | (lc_sts & ~(stat_clr_i & wdata_i[2]));
			da_sts <= da_set | (da_sts & ~(stat_clr_i & wdata_i[0]));
		end
	end

	// typePolarity fixed at 01, level low
	assign int_enable_o = {glob_en, 7'd0, 16'd0, cr_en, 2'b00, 2'b01, lc_en, 1'b0, da_en};
	assign int_status_o = {cr_sts, 4'd0, lc_sts, 1'b0, da_sts};
	assign pirq_n_o     = ~(cr_sts | lc_sts | da_sts);

endmodule

//--- hw/tpm_sts_fsm.sv
// TPM_STS command lifecycle FSM
// Drives commandReady, Expect, dataAvail and the engine start pulse
`timescale 1ns/1ps

module tpm_sts_fsm
(
	input  logic                     clock,
	input  logic                     reset_n,
	input  logic                     cmd_ready_wr_i,
	input  logic                     go_wr_i,
	input  logic                     fifo_wr_i,
	input  logic                     seized_i,		// Seize aborts any command
	input  logic                     cmd_complete_i,
	input  logic                     rsp_empty_i,
	input  logic                     exec_done_i,
	output logic                     exec_start_o,
	output tpm_fifo_pkg::sts_state_t sts_state_o,
	output logic                     cmd_ready_o,
	output logic                     expect_o,
	output logic                     data_avail_o,
	output logic                     buf_clear_o
);

	tpm_fifo_pkg::sts_state_t state_next;

	always_comb
	begin
		state_next = sts_state_o;
		case (sts_state_o)
		tpm_fifo_pkg::IDLE:
			if (cmd_ready_wr_i)
				state_next = tpm_fifo_pkg::READY;
		tpm_fifo_pkg::READY:
			if (fifo_wr_i)
				state_next = tpm_fifo_pkg::RECEPTION;	// First command byte
		tpm_fifo_pkg::RECEPTION:
			if (cmd_ready_wr_i)
				state_next = tpm_fifo_pkg::IDLE;
			else if (go_wr_i && cmd_complete_i)
				state_next = tpm_fifo_pkg::EXECUTION;	// go ignored on a partial command
		tpm_fifo_pkg::EXECUTION:
			if (cmd_ready_wr_i)
				state_next = tpm_fifo_pkg::IDLE;
			else if (exec_done_i)
				state_next = tpm_fifo_pkg::COMPLETION;
		tpm_fifo_pkg::COMPLETION:
			if (cmd_ready_wr_i)
				state_next = tpm_fifo_pkg::IDLE;
		default:
			state_next = tpm_fifo_pkg::IDLE;
		endcase
		if (seized_i)
			state_next = tpm_fifo_pkg::IDLE;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			sts_state_o  <= tpm_fifo_pkg::IDLE;
			exec_start_o <= 1'b0;
		end
		else
		begin
			sts_state_o  <= state_next;
			exec_start_o <= (sts_state_o == tpm_fifo_pkg::RECEPTION) &&
			                (state_next == tpm_fifo_pkg::EXECUTION);
		end
	end

	// Status flags straight from the state
	assign cmd_ready_o  = (sts_state_o == tpm_fifo_pkg::READY);
	assign expect_o     = (sts_state_o == tpm_fifo_pkg::RECEPTION) && !cmd_complete_i;
	assign data_avail_o = (sts_state_o == tpm_fifo_pkg::COMPLETION) && !rsp_empty_i;
	// Any drop back to Idle flushes both buffers
	assign buf_clear_o  = (sts_state_o != tpm_fifo_pkg::IDLE) &&
	                      (state_next == tpm_fifo_pkg::IDLE);

	a_start_pulse: assert property (@(posedge clock) disable iff (!reset_n)
		exec_start_o |=> !exec_start_o);

endmodule

//--- hw/tpm_locality_arb.sv
// Locality arbiter
// Tracks requestUse bits and hands the TPM to the highest requester
`timescale 1ns/1ps
`include "tpm_fifo_consts.svh"

module tpm_locality_arb
(
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic [`TPM_NUM_LOC-1:0] loc_grant_req_i,	// requestUse strobes
	input  logic [`TPM_NUM_LOC-1:0] loc_seize_i,
	input  logic [`TPM_NUM_LOC-1:0] loc_release_i,	// activeLocality write of 1
	output logic [2:0]              active_loc_o,
	output logic                    loc_valid_o,
	output logic [`TPM_NUM_LOC-1:0] locality_o,
	output logic                    seized_o,
	output logic [2:0]              seized_loc_o,
	output logic                    loc_change_o,
	output logic [`TPM_NUM_LOC-1:0] pending_o
);

	tpm_fifo_pkg::loc_state_t state, state_next;
	logic [`TPM_NUM_LOC-1:0] req_use, req_all, grant_mask;
	logic [2:0] top_req;
	logic any_req, seize_hi;

	assign loc_valid_o  = (state >= tpm_fifo_pkg::LOC_0) && (state <= tpm_fifo_pkg::LOC_4);
	assign active_loc_o = loc_valid_o ? 3'(state - tpm_fifo_pkg::LOC_0) : 3'd0;
	assign locality_o   = loc_valid_o ? ({{(`TPM_NUM_LOC-1){1'b0}}, 1'b1} << active_loc_o) : '0;
	assign loc_change_o = (state == tpm_fifo_pkg::LOC_REL);
	assign pending_o    = req_use;

	// Requests from the owner itself are ignored
	assign req_all = req_use | (loc_grant_req_i & ~locality_o);
	assign any_req = |req_all;

	// Highest pending request wins by index
	always_comb
	begin
		top_req = 3'd0;
		for (int i = 0; i < `TPM_NUM_LOC; i++)
			if (req_all[i])
				top_req = 3'(i);
	end

	// Seize only counts from above the owner
	always_comb
	begin
		seize_hi = 1'b0;
		for (int i = 0; i < `TPM_NUM_LOC; i++)
			if (loc_seize_i[i] && loc_valid_o && (3'(i) > active_loc_o))
				seize_hi = 1'b1;
	end

	always_comb
	begin
		state_next = state;
		case (state)
		tpm_fifo_pkg::LOC_NULL:
			state_next = any_req ? tpm_fifo_pkg::LOC_REL : tpm_fifo_pkg::LOC_NULL;
		tpm_fifo_pkg::LOC_REL:		// Grant or fall back to nobody
			state_next = any_req ? tpm_fifo_pkg::loc_state_t'(tpm_fifo_pkg::LOC_0 + top_req)
			                     : tpm_fifo_pkg::LOC_NULL;
		default:
			if (seize_hi || |(loc_release_i & locality_o))
				state_next = tpm_fifo_pkg::LOC_REL;
		endcase
	end

	// Winner's request bit drops at the grant
	assign grant_mask = (loc_change_o && any_req) ?
		({{(`TPM_NUM_LOC-1){1'b0}}, 1'b1} << top_req) : '0;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state        <= tpm_fifo_pkg::LOC_NULL;
			req_use      <= '0;
			seized_o     <= 1'b0;
			seized_loc_o <= 3'd0;
		end
		else
		begin
			state        <= state_next;
			req_use      <= req_all & ~loc_release_i & ~grant_mask;	// Relinquish drops a pending request
			seized_o     <= seize_hi;		// High during the handover cycle
			seized_loc_o <= active_loc_o;	// Loser of the seize
		end
	end

	// A grant lands on exactly one locality that was asking for use
	a_loc_onehot: assert property (@(posedge clock) disable iff (!reset_n)
		(loc_change_o && any_req) |=> $onehot(locality_o) &&
			((locality_o & ~$past(req_all)) == '0));

endmodule

//--- hw/tpm_fifo_pkg.sv
// TPM FIFO register space shared types
// Status lifecycle and locality arbiter state encodings
package tpm_fifo_pkg;

	// TPM_STS command lifecycle
	typedef enum logic [2:0]
	{
		IDLE       = 3'd0,	// No command, buffer empty
		READY      = 3'd1,	// commandReady set, waiting on first byte
		RECEPTION  = 3'd2,	// Command bytes arriving
		EXECUTION  = 3'd3,	// Engine owns the command
		COMPLETION = 3'd4	// Response waiting for the host
	} sts_state_t;

	// Active locality arbiter
	typedef enum logic [2:0]
	{
		LOC_NULL = 3'd0,	// Nobody holds the TPM
		LOC_REL  = 3'd1,	// Handover cycle
		LOC_0    = 3'd2,
		LOC_1    = 3'd3,
		LOC_2    = 3'd4,
		LOC_3    = 3'd5,
		LOC_4    = 3'd6	// Highest priority
	} loc_state_t;

endpackage

//--- hw/tpm_fifo_consts.svh
// TPM FIFO register space constants
// Register offsets, data windows, sizes and static ID values
`ifndef TPM_FIFO_CONSTS_SVH
`define TPM_FIFO_CONSTS_SVH

// Sizes
`define TPM_NUM_LOC      5
`define TPM_ADDR_W       16
`define TPM_BUF_DEPTH    64
`define TPM_BUF_AW       6
`define TPM_BURST_COUNT  16'd64	// Static burstCount, TPM_STS bytes 1-2

// Register offsets, byte 0 of each register
`define TPM_ACCESS_OFS   12'h000
`define TPM_INT_EN_OFS   12'h008
`define TPM_INT_STS_OFS  12'h010
`define TPM_CAP_OFS      12'h014
`define TPM_STS_OFS      12'h018
`define TPM_IFID_OFS     12'h030
`define TPM_DIDVID_OFS   12'hF00
`define TPM_RID_OFS      12'hF04

// Data windows
`define TPM_FIFO_LO      12'h024
`define TPM_FIFO_HI      12'h027
`define TPM_XFIFO_LO     12'h080
`define TPM_XFIFO_HI     12'h083

// Static register contents, byte 3 first
`define TPM_CAP_BYTES    32'h3000_07D5	// Intf 1.3, 64B transfers, PIRQ low level
`define TPM_IFID_BYTES   32'h0006_0100	// FIFO interface, localities supported
`define TPM_STS_B3       8'h04		// tpmFamily TPM 2.0
`define TPM_DID          16'h5654
`define TPM_VID          16'h3037
`define TPM_RID          8'hFF

// Idle value of the read data bus
`define TPM_READ_IDLE    8'hFF

`endif
